/* design/rs_types_pkg.sv */
package rs_types_pkg;

    // Queue and register file sizes
    localparam int NUM_RS_ENTS = 8;
    localparam int NUM_PREGS   = 64;

    // Physical register id
    typedef logic [5:0] prf_id_t;

    // Register or immediate value
    typedef logic [31:0] reg_data_t;

    // Reorder buffer id
    typedef logic [4:0] rob_id_t;

    // Slot index within the queue
    typedef logic [2:0] rs_idx_t;

    // Operand type of one source
    typedef logic [1:0] optype_t;

    localparam optype_t OP_INVD = 2'd0;
    localparam optype_t OP_ZERO = 2'd1;
    localparam optype_t OP_IMM  = 2'd2;
    localparam optype_t OP_REG  = 2'd3;

endpackage

/* design/rs_cfg_pkg.sv */
package rs_cfg_pkg;

    typedef logic [1:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // Register map
    localparam cfg_addr_t CFG_CTRL     = 2'd0;
    localparam cfg_addr_t CFG_DISP_CNT = 2'd1;
    localparam cfg_addr_t CFG_ISS_CNT  = 2'd2;
    localparam cfg_addr_t CFG_DROP_CNT = 2'd3;

    // Issue enable set out of reset
    localparam cfg_data_t CTRL_RESET = 16'h0001;

endpackage

/* design/rs_entry.sv */
`timescale 1ns/1ns

module rs_entry
    import rs_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      alloc,
    input  rob_id_t   disp_robid,
    input  prf_id_t   disp_pdst,
    input  optype_t   disp_src1_type,
    input  optype_t   disp_src2_type,
    input  prf_id_t   disp_psrc1,
    input  prf_id_t   disp_psrc2,
    input  logic      disp_src1_rdy,
    input  logic      disp_src2_rdy,
    input  reg_data_t disp_imm,

    input  logic      wb_valid,
    input  prf_id_t   wb_pdst,

    input  logic      gnt,

    output logic      valid,
    output logic      req,
    output rob_id_t   robid,
    output prf_id_t   pdst,
    output optype_t   src1_type,
    output optype_t   src2_type,
    output prf_id_t   psrc1,
    output prf_id_t   psrc2,
    output reg_data_t imm
);

logic src1_rdy;
logic src2_rdy;

// Sources that are not registers never wait
always_ff @(posedge clk) begin
    if (rst) begin
        valid    <= 1'b0;
        src1_rdy <= 1'b0;
        src2_rdy <= 1'b0;
    end else if (alloc) begin
        valid    <= 1'b1;
        src1_rdy <= (disp_src1_type != OP_REG) || disp_src1_rdy ||
                    (wb_valid && wb_pdst == disp_psrc1);
        src2_rdy <= (disp_src2_type != OP_REG) || disp_src2_rdy ||
                    (wb_valid && wb_pdst == disp_psrc2);
    end else begin
        if (gnt)
            valid <= 1'b0;
        if (wb_valid && wb_pdst == psrc1)
            src1_rdy <= 1'b1;
        if (wb_valid && wb_pdst == psrc2)
            src2_rdy <= 1'b1;
    end
end

// Micro-op payload
always_ff @(posedge clk) begin
    if (alloc) begin
        robid     <= disp_robid;
        pdst      <= disp_pdst;
        src1_type <= disp_src1_type;
        src2_type <= disp_src2_type;
        psrc1     <= disp_psrc1;
        psrc2     <= disp_psrc2;
        imm       <= disp_imm;
    end
end

assign req = valid && src1_rdy && src2_rdy;

endmodule

/* design/rs_issue.sv */
`timescale 1ns/1ns

module rs_issue
    import rs_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      disp_valid,
    input  rob_id_t   disp_robid,
    input  prf_id_t   disp_pdst,
    input  optype_t   disp_src1_type,
    input  optype_t   disp_src2_type,
    input  prf_id_t   disp_psrc1,
    input  prf_id_t   disp_psrc2,
    input  logic      disp_src1_rdy,
    input  logic      disp_src2_rdy,
    input  reg_data_t disp_imm,
    output logic      disp_accept,
    output logic      disp_drop,

    input  logic      wb_valid,
    input  prf_id_t   wb_pdst,

    input  logic      iss_en,

    output logic      prf_rd1,
    output logic      prf_rd2,
    output prf_id_t   prf_raddr1,
    output prf_id_t   prf_raddr2,
    input  reg_data_t prf_rdata1,
    input  reg_data_t prf_rdata2,

    output logic      iss_valid,
    output rob_id_t   iss_robid,
    output prf_id_t   iss_pdst,
    output reg_data_t iss_src1_val,
    output reg_data_t iss_src2_val
);

logic [NUM_RS_ENTS-1:0] ent_valid;
logic [NUM_RS_ENTS-1:0] ent_req;
logic [NUM_RS_ENTS-1:0] ent_alloc;
logic [NUM_RS_ENTS-1:0] ent_gnt;
rob_id_t                ent_robid     [NUM_RS_ENTS];
prf_id_t                ent_pdst      [NUM_RS_ENTS];
optype_t                ent_src1_type [NUM_RS_ENTS];
optype_t                ent_src2_type [NUM_RS_ENTS];
prf_id_t                ent_psrc1     [NUM_RS_ENTS];
prf_id_t                ent_psrc2     [NUM_RS_ENTS];
reg_data_t              ent_imm       [NUM_RS_ENTS];

logic    free_any;
rs_idx_t free_idx;
logic    gnt_any;
rs_idx_t gnt_idx;

rob_id_t   stg_robid;
prf_id_t   stg_pdst;
optype_t   stg_src1_type;
optype_t   stg_src2_type;
reg_data_t stg_imm;

function automatic reg_data_t opsel(optype_t optype, reg_data_t imm_val, reg_data_t reg_val);
    reg_data_t val;
    case (optype)
        OP_IMM:  val = imm_val;
        OP_REG:  val = reg_val;
        default: val = '0;
    endcase
    return val;
endfunction

// Lowest free slot and lowest requester, scanned downward so index 0 wins
always_comb begin
    free_any = 1'b0;
    free_idx = '0;
    gnt_any  = 1'b0;
    gnt_idx  = '0;
    for (int i = NUM_RS_ENTS - 1; i >= 0; i--) begin
        if (!ent_valid[i]) begin
            free_any = 1'b1;
            free_idx = rs_idx_t'(i);
        end
        if (ent_req[i]) begin
            gnt_any = iss_en;
            gnt_idx = rs_idx_t'(i);
        end
    end
end

assign disp_accept = disp_valid && free_any;
assign disp_drop   = disp_valid && !free_any;

// Register reads for the granted slot
assign prf_rd1    = gnt_any && ent_src1_type[gnt_idx] == OP_REG;
assign prf_rd2    = gnt_any && ent_src2_type[gnt_idx] == OP_REG;
assign prf_raddr1 = ent_psrc1[gnt_idx];
assign prf_raddr2 = ent_psrc2[gnt_idx];

for (genvar i = 0; i < NUM_RS_ENTS; i++) begin : g_ents
    assign ent_alloc[i] = disp_accept && free_idx == rs_idx_t'(i);
    assign ent_gnt[i]   = gnt_any && gnt_idx == rs_idx_t'(i);

    rs_entry u_ent (
        .clk            (clk),
        .rst            (rst),
        .alloc          (ent_alloc[i]),
        .disp_robid     (disp_robid),
        .disp_pdst      (disp_pdst),
        .disp_src1_type (disp_src1_type),
        .disp_src2_type (disp_src2_type),
        .disp_psrc1     (disp_psrc1),
        .disp_psrc2     (disp_psrc2),
        .disp_src1_rdy  (disp_src1_rdy),
        .disp_src2_rdy  (disp_src2_rdy),
        .disp_imm       (disp_imm),
        .wb_valid       (wb_valid),
        .wb_pdst        (wb_pdst),
        .gnt            (ent_gnt[i]),
        .valid          (ent_valid[i]),
        .req            (ent_req[i]),
        .robid          (ent_robid[i]),
        .pdst           (ent_pdst[i]),
        .src1_type      (ent_src1_type[i]),
        .src2_type      (ent_src2_type[i]),
        .psrc1          (ent_psrc1[i]),
        .psrc2          (ent_psrc2[i]),
        .imm            (ent_imm[i])
    );
end

// Issue stage, lines up with the register file read
always_ff @(posedge clk) begin
    if (rst)
        iss_valid <= 1'b0;
    else
        iss_valid <= gnt_any;
end

always_ff @(posedge clk) begin
    if (gnt_any) begin
        stg_robid     <= ent_robid[gnt_idx];
        stg_pdst      <= ent_pdst[gnt_idx];
        stg_src1_type <= ent_src1_type[gnt_idx];
        stg_src2_type <= ent_src2_type[gnt_idx];
        stg_imm       <= ent_imm[gnt_idx];
    end
end

assign iss_robid    = stg_robid;
assign iss_pdst     = stg_pdst;
assign iss_src1_val = opsel(stg_src1_type, stg_imm, prf_rdata1);
assign iss_src2_val = opsel(stg_src2_type, stg_imm, prf_rdata2);

endmodule

/* design/prf.sv */
`timescale 1ns/1ns

module prf
    import rs_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      wr,
    input  prf_id_t   waddr,
    input  reg_data_t wdata,

    input  logic      rd1,
    input  prf_id_t   raddr1,
    input  logic      rd2,
    input  prf_id_t   raddr2,
    output reg_data_t rdata1,
    output reg_data_t rdata2
);

reg_data_t regs [NUM_PREGS];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < NUM_PREGS; i++)
            regs[i] <= '0;
    end else if (wr) begin
        regs[waddr] <= wdata;
    end
end

// Reads see the array before this edge's write
always_ff @(posedge clk) begin
    if (rd1)
        rdata1 <= regs[raddr1];
    if (rd2)
        rdata2 <= regs[raddr2];
end

endmodule

/* design/rs_ctrl_regs.sv */
`timescale 1ns/1ns

module rs_ctrl_regs
    import rs_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      cfg_wr,
    input  logic      cfg_rd,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output cfg_data_t cfg_rdata,
    output logic      cfg_rvalid,

    input  logic      disp_accept,
    input  logic      disp_drop,
    input  logic      iss_valid,

    output logic      iss_en
);

cfg_data_t disp_cnt;
cfg_data_t iss_cnt;
cfg_data_t drop_cnt;

always_ff @(posedge clk) begin
    if (rst)
        iss_en <= CTRL_RESET[0];
    else if (cfg_wr && cfg_addr == CFG_CTRL)
        iss_en <= cfg_wdata[0];
end

// Counters wrap; a write to the address clears and beats the event
always_ff @(posedge clk) begin
    if (rst) begin
        disp_cnt <= '0;
        iss_cnt  <= '0;
        drop_cnt <= '0;
    end else begin
        if (cfg_wr && cfg_addr == CFG_DISP_CNT)
            disp_cnt <= '0;
        else if (disp_accept)
            disp_cnt <= disp_cnt + 1'b1;

        if (cfg_wr && cfg_addr == CFG_ISS_CNT)
            iss_cnt <= '0;
        else if (iss_valid)
            iss_cnt <= iss_cnt + 1'b1;

        if (cfg_wr && cfg_addr == CFG_DROP_CNT)
            drop_cnt <= '0;
        else if (disp_drop)
            drop_cnt <= drop_cnt + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (rst)
        cfg_rvalid <= 1'b0;
    else
        cfg_rvalid <= cfg_rd;
end

always_ff @(posedge clk) begin
    if (cfg_rd) begin
        case (cfg_addr)
            CFG_CTRL:     cfg_rdata <= {15'b0, iss_en};
            CFG_DISP_CNT: cfg_rdata <= disp_cnt;
            CFG_ISS_CNT:  cfg_rdata <= iss_cnt;
            default:      cfg_rdata <= drop_cnt;
        endcase
    end
end

endmodule

/* design/rs_unit.sv */
`timescale 1ns/1ns

module rs_unit
    import rs_types_pkg::*, rs_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      disp_valid,
    input  rob_id_t   disp_robid,
    input  prf_id_t   disp_pdst,
    input  optype_t   disp_src1_type,
    input  optype_t   disp_src2_type,
    input  prf_id_t   disp_psrc1,
    input  prf_id_t   disp_psrc2,
    input  logic      disp_src1_rdy,
    input  logic      disp_src2_rdy,
    input  reg_data_t disp_imm,

    input  logic      wb_valid,
    input  prf_id_t   wb_pdst,
    input  reg_data_t wb_data,

    input  logic      cfg_wr,
    input  logic      cfg_rd,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output cfg_data_t cfg_rdata,
    output logic      cfg_rvalid,

    output logic      iss_valid,
    output rob_id_t   iss_robid,
    output prf_id_t   iss_pdst,
    output reg_data_t iss_src1_val,
    output reg_data_t iss_src2_val
);

logic      disp_accept;
logic      disp_drop;
logic      iss_en;
logic      prf_rd1;
logic      prf_rd2;
prf_id_t   prf_raddr1;
prf_id_t   prf_raddr2;
reg_data_t prf_rdata1;
reg_data_t prf_rdata2;

rs_issue u_rs_issue (
    .clk            (clk),
    .rst            (rst),
    .disp_valid     (disp_valid),
    .disp_robid     (disp_robid),
    .disp_pdst      (disp_pdst),
    .disp_src1_type (disp_src1_type),
    .disp_src2_type (disp_src2_type),
    .disp_psrc1     (disp_psrc1),
    .disp_psrc2     (disp_psrc2),
    .disp_src1_rdy  (disp_src1_rdy),
    .disp_src2_rdy  (disp_src2_rdy),
    .disp_imm       (disp_imm),
    .disp_accept    (disp_accept),
    .disp_drop      (disp_drop),
    .wb_valid       (wb_valid),
    .wb_pdst        (wb_pdst),
    .iss_en         (iss_en),
    .prf_rd1        (prf_rd1),
    .prf_rd2        (prf_rd2),
    .prf_raddr1     (prf_raddr1),
    .prf_raddr2     (prf_raddr2),
    .prf_rdata1     (prf_rdata1),
    .prf_rdata2     (prf_rdata2),
    .iss_valid      (iss_valid),
    .iss_robid      (iss_robid),
    .iss_pdst       (iss_pdst),
    .iss_src1_val   (iss_src1_val),
    .iss_src2_val   (iss_src2_val)
);

// Writeback lands here and wakes the queue in the same cycle
prf u_prf (
    .clk    (clk),
    .rst    (rst),
    .wr     (wb_valid),
    .waddr  (wb_pdst),
    .wdata  (wb_data),
    .rd1    (prf_rd1),
    .raddr1 (prf_raddr1),
    .rd2    (prf_rd2),
    .raddr2 (prf_raddr2),
    .rdata1 (prf_rdata1),
    .rdata2 (prf_rdata2)
);

rs_ctrl_regs u_rs_ctrl_regs (
    .clk         (clk),
    .rst         (rst),
    .cfg_wr      (cfg_wr),
    .cfg_rd      (cfg_rd),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .cfg_rvalid  (cfg_rvalid),
    .disp_accept (disp_accept),
    .disp_drop   (disp_drop),
    .iss_valid   (iss_valid),
    .iss_en      (iss_en)
);

endmodule

/* tests/rs_unit_tb.sv */
`timescale 1ns/1ns

module rs_unit_tb
    import rs_types_pkg::*, rs_cfg_pkg::*;
();

logic      clk;
logic      rst;
logic      disp_valid;
rob_id_t   disp_robid;
prf_id_t   disp_pdst;
optype_t   disp_src1_type;
optype_t   disp_src2_type;
prf_id_t   disp_psrc1;
prf_id_t   disp_psrc2;
logic      disp_src1_rdy;
logic      disp_src2_rdy;
reg_data_t disp_imm;
logic      wb_valid;
prf_id_t   wb_pdst;
reg_data_t wb_data;
logic      cfg_wr;
logic      cfg_rd;
cfg_addr_t cfg_addr;
cfg_data_t cfg_wdata;
cfg_data_t cfg_rdata;
logic      cfg_rvalid;
logic      iss_valid;
rob_id_t   iss_robid;
prf_id_t   iss_pdst;
reg_data_t iss_src1_val;
reg_data_t iss_src2_val;

// Expected issues keyed by robid
logic      exp_valid [32];
prf_id_t   exp_pdst  [32];
reg_data_t exp_val1  [32];
reg_data_t exp_val2  [32];
logic      issued    [32];

// Expected control read data in request order
cfg_data_t exp_cfg [64];
int        rd_sent;
int        rd_seen;

string     lines [$];
logic      loaded;
int        run_errs;
int        iss_errs;
int        cfg_errs;

// Writeback held back to share a cycle with the next command
logic      pair_wb;
prf_id_t   pair_pdst;
reg_data_t pair_data;

rs_unit u_rs_unit (
    .clk            (clk),
    .rst            (rst),
    .disp_valid     (disp_valid),
    .disp_robid     (disp_robid),
    .disp_pdst      (disp_pdst),
    .disp_src1_type (disp_src1_type),
    .disp_src2_type (disp_src2_type),
    .disp_psrc1     (disp_psrc1),
    .disp_psrc2     (disp_psrc2),
    .disp_src1_rdy  (disp_src1_rdy),
    .disp_src2_rdy  (disp_src2_rdy),
    .disp_imm       (disp_imm),
    .wb_valid       (wb_valid),
    .wb_pdst        (wb_pdst),
    .wb_data        (wb_data),
    .cfg_wr         (cfg_wr),
    .cfg_rd         (cfg_rd),
    .cfg_addr       (cfg_addr),
    .cfg_wdata      (cfg_wdata),
    .cfg_rdata      (cfg_rdata),
    .cfg_rvalid     (cfg_rvalid),
    .iss_valid      (iss_valid),
    .iss_robid      (iss_robid),
    .iss_pdst       (iss_pdst),
    .iss_src1_val   (iss_src1_val),
    .iss_src2_val   (iss_src2_val)
);

initial clk = 1'b0;
always #50 clk = ~clk;

task automatic check_data(string what, reg_data_t got, reg_data_t exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        iss_errs++;
    end
endtask

// Issued robid must still be pending, and its pdst must match
task automatic check_rob(rob_id_t got_rob, prf_id_t got_dst);
    if (!exp_valid[got_rob]) begin
        $display("Robid %0d issued at %0t with no expected issue", got_rob, $time);
        iss_errs++;
    end else if (issued[got_rob]) begin
        $display("Robid %0d issued a second time at %0t", got_rob, $time);
        iss_errs++;
    end else if (got_dst !== exp_pdst[got_rob]) begin
        $display("Mismatch at %0t: robid %0d pdst got %h expected %h",
                 $time, got_rob, got_dst, exp_pdst[got_rob]);
        iss_errs++;
    end
endtask

task automatic check_cfg(cfg_data_t got, cfg_data_t exp);
    if (got !== exp) begin
        $display("Mismatch at %0t: control read got %h expected %h", $time, got, exp);
        cfg_errs++;
    end
endtask

function automatic logic all_issued();
    for (int i = 0; i < 32; i++)
        if (exp_valid[i] && !issued[i])
            return 1'b0;
    return 1'b1;
endfunction

task automatic load_patterns();
    int    fd;
    string line;
    fd = $fopen("tests/rs_patterns.txt", "r");
    if (fd == 0) begin
        $display("Could not open tests/rs_patterns.txt");
        run_errs++;
    end else begin
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#")
                lines.push_back(line);
        end
        $fclose(fd);
    end
endtask

// Strobes last one cycle unless the command sets them again
task automatic next_cycle();
    @(posedge clk);
    disp_valid <= 1'b0;
    wb_valid   <= 1'b0;
    cfg_wr     <= 1'b0;
    cfg_rd     <= 1'b0;
    if (pair_wb) begin
        wb_valid <= 1'b1;
        wb_pdst  <= pair_pdst;
        wb_data  <= pair_data;
        pair_wb = 1'b0;
    end
endtask

task automatic run_command(string line);
    byte         cmd;
    string       rest;
    logic [31:0] f [9];
    cmd  = line.getc(0);
    rest = line.substr(1, line.len() - 1);
    for (int i = 0; i < 9; i++)
        f[i] = '0;
    void'($sscanf(rest, "%h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]));
    case (cmd)
        "W": begin
            next_cycle();
            wb_valid <= 1'b1;
            wb_pdst  <= prf_id_t'(f[0]);
            wb_data  <= f[1];
        end
        "P": begin
            pair_wb   = 1'b1;
            pair_pdst = prf_id_t'(f[0]);
            pair_data = f[1];
        end
        "D": begin
            next_cycle();
            disp_valid     <= 1'b1;
            disp_robid     <= rob_id_t'(f[0]);
            disp_pdst      <= prf_id_t'(f[1]);
            disp_src1_type <= optype_t'(f[2]);
            disp_psrc1     <= prf_id_t'(f[3]);
            disp_src1_rdy  <= f[4][0];
            disp_src2_type <= optype_t'(f[5]);
            disp_psrc2     <= prf_id_t'(f[6]);
            disp_src2_rdy  <= f[7][0];
            disp_imm       <= f[8];
        end
        "C": begin
            next_cycle();
            cfg_wr    <= 1'b1;
            cfg_addr  <= cfg_addr_t'(f[0]);
            cfg_wdata <= cfg_data_t'(f[1]);
        end
        "R": begin
            next_cycle();
            cfg_rd   <= 1'b1;
            cfg_addr <= cfg_addr_t'(f[0]);
            if (rd_sent < 64) begin
                exp_cfg[rd_sent] = cfg_data_t'(f[1]);
                rd_sent++;
            end
        end
        "E": begin
            exp_valid[f[0][4:0]] = 1'b1;
            exp_pdst[f[0][4:0]]  = prf_id_t'(f[1]);
            exp_val1[f[0][4:0]]  = f[2];
            exp_val2[f[0][4:0]]  = f[3];
        end
        "I": repeat (f[0]) next_cycle();
        default: begin
            $display("Unknown command in pattern line: %s", line);
            run_errs++;
        end
    endcase
endtask

// Issue scoreboard
always @(negedge clk) begin
    if (rst) begin
        iss_errs = 0;
        for (int i = 0; i < 32; i++)
            issued[i] = 1'b0;
    end else if (iss_valid) begin
        check_rob(iss_robid, iss_pdst);
        if (exp_valid[iss_robid] && !issued[iss_robid]) begin
            issued[iss_robid] = 1'b1;
            check_data("src1", iss_src1_val, exp_val1[iss_robid]);
            check_data("src2", iss_src2_val, exp_val2[iss_robid]);
        end
    end
end

always @(negedge clk) begin
    if (rst) begin
        cfg_errs = 0;
        rd_seen  = 0;
    end else if (cfg_rvalid) begin
        if (rd_seen >= rd_sent) begin
            $display("Control read data arrived at %0t with no read pending", $time);
            cfg_errs++;
        end else begin
            check_cfg(cfg_rdata, exp_cfg[rd_seen]);
            rd_seen++;
        end
    end
end

initial begin
    int limit;
    wait (loaded);
    limit = lines.size() * 20 + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, simulation stopped", limit);
    for (int i = 0; i < 32; i++)
        if (exp_valid[i] && !issued[i])
            $display("Expected issue of robid %0d was never seen", i);
    $display("Errors: %0d issue, %0d control read, %0d other", iss_errs, cfg_errs, run_errs);
    $display("Testbench failed");
    $finish;
end

initial begin
    rst            = 1'b1;
    disp_valid     = 1'b0;
    disp_robid     = '0;
    disp_pdst      = '0;
    disp_src1_type = OP_INVD;
    disp_src2_type = OP_INVD;
    disp_psrc1     = '0;
    disp_psrc2     = '0;
    disp_src1_rdy  = 1'b0;
    disp_src2_rdy  = 1'b0;
    disp_imm       = '0;
    wb_valid       = 1'b0;
    wb_pdst        = '0;
    wb_data        = '0;
    cfg_wr         = 1'b0;
    cfg_rd         = 1'b0;
    cfg_addr       = '0;
    cfg_wdata      = '0;
    pair_wb        = 1'b0;
    pair_pdst      = '0;
    pair_data      = '0;
    run_errs       = 0;
    rd_sent        = 0;
    loaded         = 1'b0;
    for (int i = 0; i < 32; i++)
        exp_valid[i] = 1'b0;
    load_patterns();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    foreach (lines[n])
        run_command(lines[n]);
    next_cycle();
    while (!all_issued())
        @(posedge clk);
    repeat (3) @(posedge clk);
    if (rd_seen != rd_sent) begin
        $display("Only %0d of %0d control reads got a response", rd_seen, rd_sent);
        run_errs++;
    end
    $display("Errors: %0d issue, %0d control read, %0d other", iss_errs, cfg_errs, run_errs);
    if (iss_errs + cfg_errs + run_errs == 0)
        $display("Testbench passed");
    else
        $display("Testbench failed");
    $finish;
end

endmodule

/* tests/rs_patterns.txt */
# W reg data | P reg data (joins next command) | D robid pdst t1 p1 r1 t2 p2 r2 imm
# E robid pdst src1 src2 | C addr data | R addr expected | I cycles; types 0 invd 1 zero 2 imm 3 reg
E 01 10 00001234 00000000
D 01 10 2 00 0 1 00 0 00001234
I 4
E 02 11 cafef00d 00000055
D 02 11 3 05 0 2 00 0 00000055
I 6
W 05 cafef00d
I 4
E 03 12 00000077 00000077
P 06 00000077
D 03 12 3 06 0 3 06 0 00000000
I 4
E 04 13 0000aaaa 00000007
E 05 14 0000bbbb 0000aaaa
E 06 15 00000000 0000bbbb
D 04 13 3 07 0 2 00 0 00000007
D 05 14 3 08 0 3 07 0 00000000
D 06 15 0 00 0 3 08 0 00000000
I 2
W 07 0000aaaa
W 08 0000bbbb
I 6
C 0 0000
E 07 16 cafef00d 00000009
E 08 17 00000009 00000000
D 07 16 3 05 1 2 00 0 00000009
D 08 17 2 00 0 1 00 0 00000009
I 5
R 2 0006
R 0 0000
C 0 0001
I 5
R 2 0008
C 1 0000
C 3 0000
D 10 20 3 09 0 2 00 0 00000010
D 11 21 3 09 0 2 00 0 00000011
D 12 22 3 09 0 2 00 0 00000012
D 13 23 3 09 0 2 00 0 00000013
D 14 24 3 09 0 2 00 0 00000014
D 15 25 3 09 0 2 00 0 00000015
D 16 26 3 09 0 2 00 0 00000016
D 17 27 3 09 0 2 00 0 00000017
D 18 28 3 09 0 2 00 0 00000018
I 2
R 3 0001
R 1 0008
C 1 0000
C 3 0000
R 1 0000
R 3 0000

/* tb.f */
design/rs_types_pkg.sv
design/rs_cfg_pkg.sv
design/rs_entry.sv
design/rs_issue.sv
design/prf.sv
design/rs_ctrl_regs.sv
design/rs_unit.sv
tests/rs_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --top-module rs_unit_tb -f tb.f -o rs_unit_sim

out=$(./obj_dir/rs_unit_sim)
echo "$out"

# Exit status follows the search for the pass line
echo "$out" | grep -q "Testbench passed"
